//--- dbg_settings.svh
// ------------------------------
// Build settings of the debug block
// DBG_NUM_BKPT must stay within 1 to 4
// Offsets are byte offsets in an 8-bit register space
// ------------------------------
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

// Comparators present in the breakpoint unit
`define DBG_NUM_BKPT 4

// ------------------------------
// Register map

// Debug control and status
`define DBG_OFS_DCSR 8'h00
// Running-cycle counter
`define DBG_OFS_DCYC 8'h04
// Breakpoint control
`define DBG_OFS_BPCTRL 8'h08
// Comparator n sits at this plus 4n
`define DBG_OFS_BPCOMP0 8'h10

// Needed in bits 31:16 of every DCSR write
`define DBG_DCSR_KEY 16'hA05F

`endif

//--- dbg_pkg.sv
// ------------------------------
// Shared types of the debug block
// Register addresses carry the low byte of the host address only
// No response codes, every access answers OKAY
// ------------------------------
package dbg_pkg;

   typedef logic [31:0] dbg_word_t;       // Bus and register word
   typedef logic [29:0] dbg_faddr_t;      // Fetch word address, bits 31:2
   typedef logic [7:0]  dbg_reg_addr_t;   // Register byte offset
   typedef logic [4:0]  bpu_sel_t;        // [4] control, [3:0] comparators

   // Halt controller states
   typedef enum logic [1:0] {
      dbg_run    = 2'd0,
      dbg_halted = 2'd1,
      dbg_step   = 2'd2
   } dbg_state_e;

   // One instruction-address comparator
   typedef struct packed {
      logic [1:0]  bp_match;   // [1] upper, [0] lower half-word
      logic [26:0] comp;       // Word address bits 28:2
   } bpu_comp_t;

   // Register access out of the bus slave
   typedef struct packed {
      bpu_sel_t  sel;          // Breakpoint select, read or write
      logic      bpu_wr;       // sel belongs to a write
      logic      dcsr_wr;      // DCSR write strobe
      logic      dcyc_wr;      // DCYC write strobe
      dbg_word_t wdata;
   } dbg_reg_req_t;

   // Host-driven AXI4-Lite signals
   typedef struct packed {
      logic          awvalid;
      dbg_reg_addr_t awaddr;
      logic          wvalid;
      dbg_word_t     wdata;
      logic [3:0]    wstrb;
      logic          bready;
      logic          arvalid;
      dbg_reg_addr_t araddr;
      logic          rready;
   } axil_req_t;

   // Slave-driven AXI4-Lite signals
   typedef struct packed {
      logic      awready;
      logic      wready;
      logic      bvalid;
      logic      arready;
      logic      rvalid;
      dbg_word_t rdata;
   } axil_rsp_t;

endpackage

//--- dbg_axil_regs.sv
// ------------------------------
// AXI4-Lite slave for the debug register map
// AW and W must be presented together, one access at a time per channel
// Partial strobes complete OKAY but write nothing
// A write accept holds off a read accept for that cycle
// ------------------------------
`timescale 1ns/1ns
`include "dbg_settings.svh"

module dbg_axil_regs (
   input  logic                  dclk,
   input  logic                  dbg_reset_n,
   input  dbg_pkg::axil_req_t    axil_req_i,
   output dbg_pkg::axil_rsp_t    axil_rsp_o,
   output dbg_pkg::dbg_reg_req_t reg_req_o,
   input  dbg_pkg::dbg_word_t    bpu_rdata_i,
   input  dbg_pkg::dbg_word_t    dcsr_rdata_i,
   input  dbg_pkg::dbg_word_t    dcyc_rdata_i
);

   // ------------------------------
   // Breakpoint register decode

   // Offset to one-hot select, absent comparators never hit
   function automatic dbg_pkg::bpu_sel_t bpu_decode(input dbg_pkg::dbg_reg_addr_t ofs);
      dbg_pkg::bpu_sel_t sel;
      sel = '0;
      if (ofs == `DBG_OFS_BPCTRL) begin
         sel[4] = 1'b1;
      end
      for (int n = 0; n < `DBG_NUM_BKPT; n++) begin
         if (ofs == dbg_pkg::dbg_reg_addr_t'(`DBG_OFS_BPCOMP0 + 4 * n)) begin
            sel[n] = 1'b1;
         end
      end
      return sel;
   endfunction

   logic               bvalid_q;     // Write response pending
   logic               rvalid_q;     // Read data pending
   dbg_pkg::dbg_word_t rdata_q;
   logic               wr_acc;       // Write handshake this cycle
   logic               wr_en;        // Handshake with all strobes set
   logic               rd_acc;       // Read handshake this cycle
   dbg_pkg::bpu_sel_t  wr_sel;
   dbg_pkg::bpu_sel_t  rd_sel;
   dbg_pkg::dbg_word_t rd_word;      // Read mux out

   assign wr_acc = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
   assign wr_en  = wr_acc & (&axil_req_i.wstrb);
   assign rd_acc = axil_req_i.arvalid & ~rvalid_q & ~wr_acc;   // Write first

   assign wr_sel = bpu_decode(axil_req_i.awaddr);
   assign rd_sel = bpu_decode(axil_req_i.araddr);

   // ------------------------------
   // Register port

   always_comb begin
      reg_req_o       = '0;
      reg_req_o.wdata = axil_req_i.wdata;
      if (wr_en) begin
         reg_req_o.sel     = wr_sel;
         reg_req_o.bpu_wr  = |wr_sel;
         reg_req_o.dcsr_wr = (axil_req_i.awaddr == `DBG_OFS_DCSR);
         reg_req_o.dcyc_wr = (axil_req_i.awaddr == `DBG_OFS_DCYC);
      end else if (rd_acc) begin
         reg_req_o.sel = rd_sel;              // Steers BPU read data
      end
   end

   // Read source by offset
   always_comb begin
      rd_word = '0;                           // Unmapped reads as zero
      if (axil_req_i.araddr == `DBG_OFS_DCSR) begin
         rd_word = dcsr_rdata_i;
      end else if (axil_req_i.araddr == `DBG_OFS_DCYC) begin
         rd_word = dcyc_rdata_i;
      end else if (|rd_sel) begin
         rd_word = bpu_rdata_i;
      end
   end

   // ------------------------------
   // Response state

   always_ff @(posedge dclk or negedge dbg_reset_n) begin
      if (!dbg_reset_n) begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (wr_acc) begin
            bvalid_q <= 1'b1;
         end else if (axil_req_i.bready) begin
            bvalid_q <= 1'b0;                 // Taken by host
         end
         if (rd_acc) begin
            rvalid_q <= 1'b1;
         end else if (axil_req_i.rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   // Read data held until taken
   always_ff @(posedge dclk) begin
      if (rd_acc) begin
         rdata_q <= rd_word;
      end
   end

   always_comb begin
      axil_rsp_o.awready = wr_acc;
      axil_rsp_o.wready  = wr_acc;
      axil_rsp_o.bvalid  = bvalid_q;
      axil_rsp_o.arready = rd_acc;
      axil_rsp_o.rvalid  = rvalid_q;
      axil_rsp_o.rdata   = rdata_q;
   end

endmodule

//--- dbg_bpu.sv
// ------------------------------
// Breakpoint unit, half-word match on instruction fetches
// Only fetches below 0x2000_0000 can match
// Control writes need the key in bit 1
// All comparator state resets to zero
// ------------------------------
`timescale 1ns/1ns
`include "dbg_settings.svh"

module dbg_bpu (
   input  logic                  dclk,
   input  logic                  dbg_reset_n,
   input  dbg_pkg::dbg_reg_req_t reg_req_i,
   input  dbg_pkg::dbg_faddr_t   fetch_addr_i,
   input  logic                  fetch_adv_i,
   input  logic                  debugen_i,
   output dbg_pkg::dbg_word_t    rdata_o,
   output logic [1:0]            match_o
);

   localparam int NB = `DBG_NUM_BKPT;

   logic               bpu_en_q;            // Master enable
   logic [NB-1:0]      comp_en_q;           // Per comparator enable
   dbg_pkg::bpu_comp_t comp_q [NB];
   logic [1:0]         match_q;
   logic               ctrl_wr;
   logic [NB-1:0]      comp_wr;
   dbg_pkg::bpu_comp_t comp_nxt;
   logic               fetch_code;          // Fetch in code region
   logic [1:0]         match_any;           // OR of all comparators
   dbg_pkg::dbg_word_t ctrl_word;

   // ------------------------------
   // Write decode

   assign ctrl_wr  = reg_req_i.bpu_wr & reg_req_i.sel[4] & reg_req_i.wdata[1];
   assign comp_wr  = {NB{reg_req_i.bpu_wr}} & reg_req_i.sel[NB-1:0];
   assign comp_nxt = {reg_req_i.wdata[31:30], reg_req_i.wdata[28:2]};

   always_ff @(posedge dclk or negedge dbg_reset_n) begin
      if (!dbg_reset_n) begin
         bpu_en_q  <= 1'b0;
         comp_en_q <= '0;
         for (int n = 0; n < NB; n++) begin
            comp_q[n] <= '0;
         end
      end else begin
         if (ctrl_wr) begin
            bpu_en_q <= reg_req_i.wdata[0];
         end
         for (int n = 0; n < NB; n++) begin
            if (comp_wr[n]) begin
               comp_en_q[n] <= reg_req_i.wdata[0];
               comp_q[n]    <= comp_nxt;
            end
         end
      end
   end

   // ------------------------------
   // Match logic

   assign fetch_code = (fetch_addr_i[29:27] == 3'b000);   // Address bits 31:29

   always_comb begin
      match_any = 2'b00;
      for (int n = 0; n < NB; n++) begin
         // Word hit gives the half-words the comparator asks for
         if (comp_en_q[n] && (fetch_addr_i[26:0] == comp_q[n].comp)) begin
            match_any = match_any | comp_q[n].bp_match;
         end
      end
   end

   // Frozen while the core stalls
   always_ff @(posedge dclk or negedge dbg_reset_n) begin
      if (!dbg_reset_n) begin
         match_q <= 2'b00;
      end else if (fetch_adv_i) begin
         match_q <= {2{debugen_i & bpu_en_q & fetch_code}} & match_any;
      end
   end

   assign match_o = match_q;

   // ------------------------------
   // Read data

   assign ctrl_word = {24'd0,          // Reserved
                       4'(NB),         // Comparator count
                       3'd0,           // Key reads zero
                       bpu_en_q};

   always_comb begin
      rdata_o = '0;
      if (reg_req_i.sel[4]) begin
         rdata_o = ctrl_word;
      end
      for (int n = 0; n < NB; n++) begin
         if (reg_req_i.sel[n]) begin
            rdata_o = {comp_q[n].bp_match,   // 31:30
                       1'b0,
                       comp_q[n].comp,       // 28:2
                       1'b0,
                       comp_en_q[n]};
         end
      end
   end

endmodule

//--- dbg_halt_ctrl.sv
// ------------------------------
// Halt controller, run, halted and single step
// DCSR writes without the key are dropped whole
// Each matched fetch can halt only once
// ------------------------------
`timescale 1ns/1ns
`include "dbg_settings.svh"

module dbg_halt_ctrl (
   input  logic                  dclk,
   input  logic                  dbg_reset_n,
   input  dbg_pkg::dbg_reg_req_t reg_req_i,
   input  logic [1:0]            match_i,
   input  logic                  fetch_adv_i,
   output logic                  debugen_o,
   output dbg_pkg::dbg_state_e   state_o,
   output logic                  halt_o,
   output dbg_pkg::dbg_word_t    dcsr_rdata_o
);

   dbg_pkg::dbg_state_e state_q;
   logic                debugen_q;
   logic                bkpt_rsn_q;     // Halted on breakpoint
   logic                step_rsn_q;     // Halted after step
   logic                adv_q;          // match_i is fresh
   logic                dcsr_wr;        // Keyed write
   logic                halt_req;
   logic                step_req;
   logic                resume_req;
   logic                bkpt_hit;

   assign dcsr_wr    = reg_req_i.dcsr_wr & (reg_req_i.wdata[31:16] == `DBG_DCSR_KEY);
   assign halt_req   = dcsr_wr & reg_req_i.wdata[1] & reg_req_i.wdata[0];  // New debugen
   assign step_req   = dcsr_wr & reg_req_i.wdata[2];
   assign resume_req = dcsr_wr & reg_req_i.wdata[3];
   assign bkpt_hit   = debugen_q & adv_q & (|match_i);

   // ------------------------------
   // FSM and DCSR state

   always_ff @(posedge dclk or negedge dbg_reset_n) begin
      if (!dbg_reset_n) begin
         state_q    <= dbg_pkg::dbg_run;
         debugen_q  <= 1'b0;
         bkpt_rsn_q <= 1'b0;
         step_rsn_q <= 1'b0;
         adv_q      <= 1'b0;
      end else begin
         adv_q <= fetch_adv_i;
         if (dcsr_wr) begin
            debugen_q <= reg_req_i.wdata[0];
         end
         case (state_q)
            dbg_pkg::dbg_run: begin
               if (halt_req) begin
                  state_q <= dbg_pkg::dbg_halted;   // Host request, no reason bit
               end else if (bkpt_hit) begin
                  state_q    <= dbg_pkg::dbg_halted;
                  bkpt_rsn_q <= 1'b1;
               end
            end
            dbg_pkg::dbg_halted: begin
               if (resume_req || step_req) begin
                  bkpt_rsn_q <= 1'b0;
                  step_rsn_q <= 1'b0;
               end
               // Resume wins over step
               if (resume_req) begin
                  state_q <= dbg_pkg::dbg_run;
               end else if (step_req) begin
                  state_q <= dbg_pkg::dbg_step;
               end
            end
            dbg_pkg::dbg_step: begin
               if (resume_req) begin
                  state_q <= dbg_pkg::dbg_run;
               end else if (fetch_adv_i) begin
                  state_q    <= dbg_pkg::dbg_halted;   // One fetch done
                  step_rsn_q <= 1'b1;
               end
            end
            default: state_q <= dbg_pkg::dbg_run;
         endcase
      end
   end

   assign state_o   = state_q;
   assign halt_o    = (state_q == dbg_pkg::dbg_halted);
   assign debugen_o = debugen_q;

   assign dcsr_rdata_o = {13'd0,
                          step_rsn_q,    // 18
                          bkpt_rsn_q,    // 17
                          halt_o,        // 16
                          15'd0,
                          debugen_q};    // 0

endmodule

//--- dbg_cycle_counter.sv
// ------------------------------
// Running-cycle counter
// Counts advanced cycles outside halted, wraps at 2^32
// Any DCYC write clears it
// ------------------------------
`timescale 1ns/1ns

module dbg_cycle_counter (
   input  logic                  dclk,
   input  logic                  dbg_reset_n,
   input  dbg_pkg::dbg_reg_req_t reg_req_i,
   input  logic                  fetch_adv_i,
   input  dbg_pkg::dbg_state_e   state_i,
   output dbg_pkg::dbg_word_t    count_o
);

   dbg_pkg::dbg_word_t count_q;
   logic               count_en;      // Core moved and not halted

   assign count_en = fetch_adv_i & (state_i != dbg_pkg::dbg_halted);

   always_ff @(posedge dclk or negedge dbg_reset_n) begin
      if (!dbg_reset_n) begin
         count_q <= '0;
      end else if (reg_req_i.dcyc_wr) begin
         count_q <= '0;               // Host clear, data ignored
      end else if (count_en) begin
         count_q <= count_q + 32'd1;
      end
   end

   assign count_o = count_q;

endmodule

//--- dbg_top.sv
// ------------------------------
// Debug block top level
// Host side is AXI4-Lite, core side is fetch address and advance
// halt_o and match_o are registered
// ------------------------------
`timescale 1ns/1ns

module dbg_top (
   input  logic                dclk,
   input  logic                dbg_reset_n,
   input  dbg_pkg::axil_req_t  axil_req_i,
   output dbg_pkg::axil_rsp_t  axil_rsp_o,
   input  dbg_pkg::dbg_faddr_t fetch_addr_i,
   input  logic                fetch_adv_i,
   output logic                halt_o,
   output logic [1:0]          match_o
);

   dbg_pkg::dbg_reg_req_t reg_req;      // Slave to register owners
   dbg_pkg::dbg_word_t    bpu_rdata;
   dbg_pkg::dbg_word_t    dcsr_rdata;
   dbg_pkg::dbg_word_t    dcyc_rdata;
   dbg_pkg::dbg_state_e   state;
   logic                  debugen;

   // ------------------------------
   // Bus slave
   dbg_axil_regs u_regs (
      .dclk         (dclk),
      .dbg_reset_n  (dbg_reset_n),
      .axil_req_i   (axil_req_i),
      .axil_rsp_o   (axil_rsp_o),
      .reg_req_o    (reg_req),
      .bpu_rdata_i  (bpu_rdata),
      .dcsr_rdata_i (dcsr_rdata),
      .dcyc_rdata_i (dcyc_rdata)
   );

   dbg_bpu u_bpu (
      .dclk         (dclk),
      .dbg_reset_n  (dbg_reset_n),
      .reg_req_i    (reg_req),
      .fetch_addr_i (fetch_addr_i),
      .fetch_adv_i  (fetch_adv_i),
      .debugen_i    (debugen),
      .rdata_o      (bpu_rdata),
      .match_o      (match_o)
   );

   // Match flags feed the halt FSM
   dbg_halt_ctrl u_halt (
      .dclk         (dclk),
      .dbg_reset_n  (dbg_reset_n),
      .reg_req_i    (reg_req),
      .match_i      (match_o),
      .fetch_adv_i  (fetch_adv_i),
      .debugen_o    (debugen),
      .state_o      (state),
      .halt_o       (halt_o),
      .dcsr_rdata_o (dcsr_rdata)
   );

   dbg_cycle_counter u_cyc (
      .dclk         (dclk),
      .dbg_reset_n  (dbg_reset_n),
      .reg_req_i    (reg_req),
      .fetch_adv_i  (fetch_adv_i),
      .state_i      (state),
      .count_o      (dcyc_rdata)
   );

endmodule

//--- tb_clock_gen.sv
// ------------------------------
// Testbench clock and reset
// 4 ns period, reset low for 5 cycles
// Reset leaves on a falling edge
// ------------------------------
`timescale 1ns/1ns

module tb_clock_gen (
   output logic dclk_o,
   output logic dbg_reset_n_o
);

   initial begin
      dclk_o        = 1'b0;
      dbg_reset_n_o = 1'b0;
      repeat (5) @(posedge dclk_o);
      @(negedge dclk_o);
      dbg_reset_n_o = 1'b1;            // Away from the sampling edge
   end

   always #2 dclk_o = ~dclk_o;

endmodule

//--- tb_dbg_assertions.sv
// ------------------------------
// Bus and select checks, bound into the AXI4-Lite slave
// fail_count is read by the testbench at the end
// ------------------------------
`timescale 1ns/1ns

module tb_dbg_assertions (
   input logic                  dclk,
   input logic                  dbg_reset_n,
   input dbg_pkg::axil_req_t    req_i,
   input dbg_pkg::axil_rsp_t    rsp_i,
   input dbg_pkg::dbg_reg_req_t reg_req_i
);

   int fail_count = 0;

   // Select is zero or one-hot
   sel_onehot: assert property (@(posedge dclk) disable iff (!dbg_reset_n)
         $onehot0(reg_req_i.sel))
      else begin
         fail_count++;
         $error("breakpoint select has more than one bit set: %b", reg_req_i.sel);
      end

   // ------------------------------
   // Responses held until taken
   bvalid_hold: assert property (@(posedge dclk) disable iff (!dbg_reset_n)
         rsp_i.bvalid && !req_i.bready |=> rsp_i.bvalid)
      else begin
         fail_count++;
         $error("bvalid dropped before bready");
      end

   rvalid_hold: assert property (@(posedge dclk) disable iff (!dbg_reset_n)
         rsp_i.rvalid && !req_i.rready |=> rsp_i.rvalid)
      else begin
         fail_count++;
         $error("rvalid dropped before rready");
      end

   // No new write while a response waits
   aw_blocked: assert property (@(posedge dclk) disable iff (!dbg_reset_n)
         !(rsp_i.awready && rsp_i.bvalid))
      else begin
         fail_count++;
         $error("awready high while bvalid pending");
      end

endmodule

bind dbg_axil_regs tb_dbg_assertions u_sva (
   .dclk        (dclk),
   .dbg_reset_n (dbg_reset_n),
   .req_i       (axil_req_i),
   .rsp_i       (axil_rsp_o),
   .reg_req_i   (reg_req_o)
);

//--- tb_dbg_top.sv
// ------------------------------
// Testbench of the debug block
// Runs the command lines of tb_dbg_input.txt
// Inputs change on the falling edge, ready is sampled on the rising edge
// Every handshake wait gives up after 50 cycles
// ------------------------------
`timescale 1ns/1ns

module tb_dbg_top;

   logic                dclk;
   logic                dbg_reset_n;
   dbg_pkg::axil_req_t  req;
   dbg_pkg::axil_rsp_t  rsp;
   dbg_pkg::dbg_faddr_t fetch_addr;
   logic                fetch_adv;
   logic                halt;
   logic [1:0]          match;

   int    errors;
   int    test_errs;          // Errors in the running test
   int    checks;
   int    tests;
   int    tests_failed;
   string tname;
   logic  in_test;

   tb_clock_gen u_clk (
      .dclk_o        (dclk),
      .dbg_reset_n_o (dbg_reset_n)
   );

   dbg_top dut_i (
      .dclk         (dclk),
      .dbg_reset_n  (dbg_reset_n),
      .axil_req_i   (req),
      .axil_rsp_o   (rsp),
      .fetch_addr_i (fetch_addr),
      .fetch_adv_i  (fetch_adv),
      .halt_o       (halt),
      .match_o      (match)
   );

   // ------------------------------
   // Result bookkeeping

   task automatic count_failure(input string what);
      $display("at %0t ns: %s", $time, what);
      test_errs++;
      errors++;
   endtask

   task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("error at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
         test_errs++;
         errors++;
      end
   endtask

   task automatic close_test();
      if (in_test) begin
         tests++;
         if (test_errs != 0) tests_failed++;
         $display("%-12s done, %0d errors", tname, test_errs);
      end
      test_errs = 0;
   endtask

   // ------------------------------
   // Bus and core drivers

   task automatic bus_write(input logic [7:0] a, input logic [31:0] d, input logic [3:0] s,
                            input int hold);
      int   n;
      logic got;
      @(negedge dclk);
      req.awvalid = 1'b1;
      req.awaddr  = a;
      req.wvalid  = 1'b1;
      req.wdata   = d;
      req.wstrb   = s;
      n   = 0;
      got = 1'b0;
      while (!got && n < 50) begin
         @(posedge dclk);
         got = rsp.awready & rsp.wready;
         n++;
      end
      if (!got) count_failure($sformatf("write to %h not accepted in 50 cycles", a));
      @(negedge dclk);
      req.awvalid = (hold > 0);               // Same write again, must wait
      req.wvalid  = (hold > 0);
      for (int k = 0; k < hold; k++) begin
         @(posedge dclk);
         if (rsp.awready | rsp.wready) count_failure("write accepted while bvalid was pending");
         @(negedge dclk);
         if (!rsp.bvalid) count_failure("bvalid dropped before bready");
      end
      req.awvalid = 1'b0;
      req.wvalid  = 1'b0;
      req.bready  = 1'b1;
      n   = 0;
      got = 1'b0;
      while (!got && n < 50) begin
         @(posedge dclk);
         got = rsp.bvalid;
         n++;
      end
      if (!got) count_failure($sformatf("no write response for %h in 50 cycles", a));
      @(negedge dclk);
      req.bready = 1'b0;
   endtask

   task automatic bus_read(input logic [7:0] a, input logic [31:0] exp, input int hold);
      int          n;
      logic        got;
      logic [31:0] data;
      @(negedge dclk);
      req.arvalid = 1'b1;
      req.araddr  = a;
      n   = 0;
      got = 1'b0;
      while (!got && n < 50) begin
         @(posedge dclk);
         got = rsp.arready;
         n++;
      end
      if (!got) count_failure($sformatf("read of %h not accepted in 50 cycles", a));
      @(negedge dclk);
      req.arvalid = (hold > 0);               // Second read stays pending
      for (int k = 0; k < hold; k++) begin
         @(posedge dclk);
         if (rsp.arready) count_failure("read accepted while read data was pending");
         @(negedge dclk);
         if (!rsp.rvalid) count_failure("rvalid dropped before rready");
      end
      req.arvalid = 1'b0;
      req.rready  = 1'b1;
      n    = 0;
      got  = 1'b0;
      data = '0;
      while (!got && n < 50) begin
         @(posedge dclk);
         got  = rsp.rvalid;
         data = rsp.rdata;
         n++;
      end
      if (!got) count_failure($sformatf("no read data for %h in 50 cycles", a));
      else check_value($sformatf("rdata of %h", a), data, exp);
      @(negedge dclk);
      req.rready = 1'b0;
   endtask

   // One advanced fetch, flags one edge later, halt one more
   task automatic core_fetch(input logic [29:0] addr, input logic [1:0] m, input logic h);
      @(negedge dclk);
      fetch_addr = addr;
      fetch_adv  = 1'b1;
      @(negedge dclk);
      fetch_adv = 1'b0;
      check_value("match_o", {30'd0, match}, {30'd0, m});
      @(negedge dclk);
      check_value("halt_o", {31'd0, halt}, {31'd0, h});
   endtask

   task automatic idle_cycles(input int cycles, input logic adv);
      @(negedge dclk);
      fetch_adv = adv;
      repeat (cycles) @(negedge dclk);
      fetch_adv = 1'b0;
   endtask

   // ------------------------------
   // Command loop

   initial begin
      int                 fd;
      int                 r;
      int                 n;
      int                 num;
      string              cmd;
      logic [31:0]        v1;
      logic [31:0]        v2;
      logic [31:0]        v3;
      logic [8*128-1:0]   skip_line;
      req          = '0;
      fetch_addr   = '0;
      fetch_adv    = 1'b0;
      errors       = 0;
      test_errs    = 0;
      checks       = 0;
      tests        = 0;
      tests_failed = 0;
      in_test      = 1'b0;
      n = 0;
      while (dbg_reset_n !== 1'b1 && n < 50) begin
         @(negedge dclk);
         n++;
      end
      if (dbg_reset_n !== 1'b1) count_failure("reset was never released");
      check_value("halt_o after reset", {31'd0, halt}, 32'd0);
      check_value("match_o after reset", {30'd0, match}, 32'd0);
      fd = $fopen("tb_dbg_input.txt", "r");
      if (fd == 0) begin
         count_failure("cannot open tb_dbg_input.txt");
      end else begin
         while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
               r = $fgets(skip_line, fd);    // Comment line
            end else if (cmd == "test") begin
               close_test();
               r = $fscanf(fd, "%s", tname);
               if (r != 1) count_failure("test line without a name in the input file");
               in_test = 1'b1;
            end else if (cmd == "write") begin
               r = $fscanf(fd, "%h %h %h %d", v1, v2, v3, num);
               if (r != 4) count_failure("malformed write line in the input file");
               bus_write(v1[7:0], v2, v3[3:0], num);
            end else if (cmd == "read") begin
               r = $fscanf(fd, "%h %h %d", v1, v2, num);
               if (r != 3) count_failure("malformed read line in the input file");
               bus_read(v1[7:0], v2, num);
            end else if (cmd == "fetch") begin
               r = $fscanf(fd, "%h %h %h", v1, v2, v3);
               if (r != 3) count_failure("malformed fetch line in the input file");
               core_fetch(v1[29:0], v2[1:0], v3[0]);
            end else if (cmd == "idle") begin
               r = $fscanf(fd, "%d %h", num, v1);
               if (r != 2) count_failure("malformed idle line in the input file");
               idle_cycles(num, v1[0]);
            end else begin
               count_failure($sformatf("unknown command %s in the input file", cmd));
            end
         end
         $fclose(fd);
      end
      close_test();
      errors = errors + dut_i.u_regs.u_sva.fail_count;   // Bound assertion failures
      $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
               tests, tests_failed, checks, errors, dut_i.u_regs.u_sva.fail_count);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- tb_dbg_input.txt
# write <ofs> <data> <wstrb> <hold>, read <ofs> <expect> <hold>, test <name>
# fetch <word addr> <match_o> <halt_o>, idle <cycles> <adv>, hold = cycles of back-pressure
test reset
read 00 00000000 0
read 04 00000000 0
read 08 00000040 0
read 10 00000000 0
read 14 00000000 0
read 1c 00000000 0
read 0c 00000000 0
read 20 00000000 0
test bpregs
write 14 ffffffff f 0
read 14 dffffffd 0
write 14 00000000 f 0
read 14 00000000 0
write 08 00000001 f 0
read 08 00000040 0
write 08 00000003 f 0
read 08 00000041 0
write 08 00000002 7 0
read 08 00000041 0
test bkpt
write 00 a05f0001 f 0
write 00 12340000 f 0
read 00 00000001 0
write 14 c000048d f 0
read 14 c000048d 0
fetch 00000124 0 0
fetch 08000123 0 0
fetch 00000123 3 1
read 00 00030001 0
write 00 a05f0009 f 0
read 00 00000001 0
write 00 a05f0000 f 0
fetch 00000123 0 0
read 00 00000000 0
test step
write 00 a05f0003 f 0
read 00 00010001 0
write 00 a05f0005 f 0
read 00 00000001 0
fetch 00000200 0 1
read 00 00050001 0
idle 3 1
read 00 00050001 0
write 00 a05f0009 f 0
fetch 00000200 0 0
test dcyc
write 04 00000000 f 0
idle 10 1
read 04 0000000a 0
write 00 a05f0003 f 0
idle 5 1
read 04 0000000a 0
write 00 a05f0009 f 0
idle 3 1
read 04 0000000d 0
idle 4 0
read 04 0000000d 0
write 04 12345678 f 0
read 04 00000000 0
test backpressure
write 18 40000009 f 3
read 18 40000009 2
write 10 00000000 f 4
read 10 00000000 3
read 08 00000041 2

//--- compile.f
+incdir+.
dbg_pkg.sv
dbg_axil_regs.sv
dbg_bpu.sv
dbg_halt_ctrl.sv
dbg_cycle_counter.sv
dbg_top.sv
tb_clock_gen.sv
tb_dbg_assertions.sv
tb_dbg_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the debug block testbench with Verilator
# Fails when the log holds the fail message or lacks the pass message
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module tb_dbg_top -f compile.f -o tb_dbg_sim || exit 1
./obj_dir/tb_dbg_sim +verilator+error+limit+100 > sim.log 2>&1 \
   || echo "simulation stopped with an error status" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log && exit 0 || exit 1
